// File: verif/pipe_ctrl_tests.txt
# in: tag cycles rs1 rs2 ex_mem1{rd wr_op} mem1_mem2{rd wr_op} mem2_wb{rd wr_op} stl csr trap br plvl mst irq
# out: fwd wb_lsu stall flush new_pc pc_sel mret is_trap mcause (wr_op = {write_rd, mem_oper})
fwd_em_rs1 1 05 06 05 10 00 00 00 00 0 0 10 0 3 0 0 20 0 00 00 0 0 0 0 00
fwd_all 1 07 07 07 10 07 10 07 13 0 0 10 0 3 0 0 3f 1 00 00 0 0 0 0 00
fwd_rs2_older 1 01 0a 0b 10 0a 10 0a 10 0 0 10 0 3 0 0 05 0 00 00 0 0 0 0 00
fwd_x0 1 00 00 00 10 00 10 00 13 0 0 10 0 3 0 0 00 1 00 00 0 0 0 0 00
fwd_no_write 1 03 04 03 00 04 08 03 00 0 0 10 0 3 0 0 00 0 00 00 0 0 0 0 00
load_use_em 1 08 09 09 13 00 00 00 00 0 0 10 0 3 0 0 00 0 18 04 0 0 0 0 00
load_use_mm 1 0c 0d 01 10 0c 15 00 00 0 0 10 0 3 0 0 08 0 18 04 0 0 0 0 00
load_mm_fwd 1 0c 0d 0c 10 0c 13 00 00 0 0 10 0 3 0 0 28 0 00 00 0 0 0 0 00
load_mm_rs2 1 0e 0f 0e 10 0f 13 00 00 0 0 10 0 3 0 0 24 0 18 04 0 0 0 0 00
mem2_stall 1 00 00 00 00 00 00 00 00 2 0 10 0 3 0 0 00 0 1e 01 0 0 0 0 00
lsu_stall 1 00 00 00 00 00 00 00 00 1 0 10 0 3 0 0 00 0 1c 02 0 0 0 0 00
stall_masks 1 08 09 09 13 00 00 00 00 1 0 10 0 3 0 0 00 0 1c 02 0 0 0 0 00
csr_id 1 00 00 00 00 00 00 00 00 0 8 10 0 3 0 0 00 0 00 10 0 0 0 0 00
csr_ex 1 00 00 00 00 00 00 00 00 0 4 10 0 3 0 0 00 0 10 10 0 0 0 0 00
csr_mem2 1 00 00 00 00 00 00 00 00 0 1 10 0 3 0 0 00 0 10 10 0 0 0 0 00
trap_ecall 1 00 00 00 00 00 00 00 00 0 0 08 0 3 0 0 00 0 00 0c 1 1 0 1 08
mret 1 00 00 00 00 00 00 00 00 0 0 11 0 3 0 0 00 0 00 0c 1 2 1 0 01
trap_first 1 00 00 00 00 00 00 00 00 0 0 05 1 3 1 7 00 0 00 0c 1 1 0 1 05
branch 1 00 00 00 00 00 00 00 00 0 0 10 1 3 0 0 00 0 00 08 1 0 0 0 00
irq_masked 1 00 00 00 00 00 00 00 00 0 0 10 0 3 0 2 00 0 00 00 0 0 0 0 00
irq_sw 1 00 00 00 00 00 00 00 00 0 0 10 0 3 1 7 00 0 00 0c 1 1 0 1 13
holdoff_branch 1 00 00 00 00 00 00 00 00 0 0 10 1 0 0 2 00 0 00 08 1 0 0 0 00
irq_umode 1 00 00 00 00 00 00 00 00 0 0 10 0 0 0 6 00 0 00 0c 1 1 0 1 17
holdoff_mret 1 00 00 00 00 00 00 00 00 0 0 11 0 3 1 4 00 0 00 0c 1 2 1 0 01
irq_hold 2 00 00 00 00 00 00 00 00 0 0 10 0 3 1 4 00 0 00 00 0 0 0 0 00
irq_again 1 00 00 00 00 00 00 00 00 0 0 10 0 3 1 4 00 0 00 0c 1 1 0 1 1b
quiet 1 00 00 00 00 00 00 00 00 0 0 10 0 3 0 0 00 0 00 00 0 0 0 0 00

// File: pipe_ctrl.f
source/pipe_ctrl_pkg.sv
source/stage_if.sv
source/forward_unit.sv
source/hazard_unit.sv
source/trap_unit.sv
source/pipe_ctrl.sv
verif/pipe_ctrl_props.sv
verif/pipe_ctrl_tb.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  # RTL in compile order
  - files:
      - source/pipe_ctrl_pkg.sv
      - source/stage_if.sv
      - source/forward_unit.sv
      - source/hazard_unit.sv
      - source/trap_unit.sv
      - source/pipe_ctrl.sv

  # testbench, top module pipe_ctrl_tb
  - target: test
    files:
      - verif/pipe_ctrl_props.sv
      - verif/pipe_ctrl_tb.sv

// File: verif/pipe_ctrl_tb.sv
// ########################################
// testbench for the pipeline control block
// vectors are read from a text file
// ########################################
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_tb;

    localparam int DATA_W = 32;
    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 8;
    localparam int RESET_TIMEOUT = 40;
    localparam int MAX_CYCLES = 400;
    localparam int MAX_TEST_CYCLES = 16;

    logic clk_i;
    logic rstn_i;

    logic [4:0] id_ex_rs1_addr_i;
    logic [4:0] id_ex_rs2_addr_i;
    logic ex_new_pc_en_i;
    logic [4:0] ex_mem1_rd_addr_i;
    logic ex_mem1_write_rd_i;
    pipe_ctrl_pkg::mem_oper_t ex_mem1_mem_oper_i;
    logic [DATA_W-1:0] ex_mem1_alu_result_i;
    logic [4:0] mem1_mem2_rd_addr_i;
    logic mem1_mem2_write_rd_i;
    pipe_ctrl_pkg::mem_oper_t mem1_mem2_mem_oper_i;
    logic [DATA_W-1:0] mem1_mem2_alu_result_i;
    logic [4:0] mem2_wb_rd_addr_i;
    logic mem2_wb_write_rd_i;
    pipe_ctrl_pkg::mem_oper_t mem2_wb_mem_oper_i;
    logic [DATA_W-1:0] mem2_wb_alu_result_i;
    logic [DATA_W-1:0] lsu_rdata_i;
    logic mem2_stall_needed_i;
    pipe_ctrl_pkg::exc_t mem_trap_i;
    logic lsu_req_stall_i;
    logic id_is_csr_i;
    logic ex_is_csr_i;
    logic mem1_is_csr_i;
    logic mem2_is_csr_i;
    pipe_ctrl_pkg::priv_lvl_e current_plvl_i;
    pipe_ctrl_pkg::mstatus_t csr_mstatus_i;
    pipe_ctrl_pkg::irqs_t irq_pending_i;

    logic fwd_ex_mem1_rs1_o;
    logic fwd_ex_mem1_rs2_o;
    logic [DATA_W-1:0] fwd_ex_mem1_data_o;
    logic fwd_mem1_mem2_rs1_o;
    logic fwd_mem1_mem2_rs2_o;
    logic [DATA_W-1:0] fwd_mem1_mem2_data_o;
    logic fwd_mem2_wb_rs1_o;
    logic fwd_mem2_wb_rs2_o;
    logic [DATA_W-1:0] fwd_mem2_wb_data_o;
    logic new_pc_en_o;
    pipe_ctrl_pkg::pc_sel_t pc_sel_o;
    logic csr_mret_o;
    pipe_ctrl_pkg::mcause_t csr_mcause_o;
    logic is_trap_o;
    logic if_id_stall_o;
    logic if_id_flush_o;
    logic id_ex_stall_o;
    logic id_ex_flush_o;
    logic ex_mem1_stall_o;
    logic ex_mem1_flush_o;
    logic mem1_mem2_stall_o;
    logic mem1_mem2_flush_o;
    logic mem2_wb_stall_o;
    logic mem2_wb_flush_o;

    // fields of the current vector line
    int in_rs1, in_rs2, in_em_rd, in_em_wop, in_mm_rd, in_mm_wop, in_mw_rd, in_mw_wop;
    int in_stl, in_csr, in_trap, in_br, in_plvl, in_mst, in_irq;
    int exp_fwd, exp_wbsel, exp_stall, exp_flush;
    int exp_npc, exp_psel, exp_mret, exp_trap, exp_mcause;
    // random operand values whose routing alone matters
    logic [DATA_W-1:0] em_res, mm_res, mw_res, lsu_data;

    int errors;
    int tests_run;
    int tests_failed;
    int total_cycles;
    logic timed_out;

    pipe_ctrl #(.DATA_W(DATA_W)) uut (.*);

    bind pipe_ctrl pipe_ctrl_props u_props (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .mem2_stall_needed_i(mem2_stall_needed_i),
        .lsu_req_stall_i    (lsu_req_stall_i),
        .hz_ex_mem1_flush_i (hz_ex_mem1_flush),
        .fwd_ex_mem1_rs1_i  (fwd_ex_mem1_rs1_o),
        .fwd_ex_mem1_rs2_i  (fwd_ex_mem1_rs2_o),
        .ex_mem1_mem_oper_i (ex_mem1_mem_oper_i),
        .csr_mret_i         (csr_mret_o),
        .pc_sel_i           (pc_sel_o)
    );

    initial
        clk_i = 1'b0;

    always #(CLK_HALF) clk_i = ~clk_i;

    // reset held for a fixed number of cycles and released off the edge
    initial
    begin
        rstn_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
    end

    task automatic check_val(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    // vector fields onto the DUT ports
    task automatic apply_inputs();
        id_ex_rs1_addr_i = in_rs1[4:0];
        id_ex_rs2_addr_i = in_rs2[4:0];
        ex_mem1_rd_addr_i = in_em_rd[4:0];
        ex_mem1_write_rd_i = in_em_wop[4];
        ex_mem1_mem_oper_i = pipe_ctrl_pkg::mem_oper_t'(in_em_wop[3:0]);
        ex_mem1_alu_result_i = em_res;
        mem1_mem2_rd_addr_i = in_mm_rd[4:0];
        mem1_mem2_write_rd_i = in_mm_wop[4];
        mem1_mem2_mem_oper_i = pipe_ctrl_pkg::mem_oper_t'(in_mm_wop[3:0]);
        mem1_mem2_alu_result_i = mm_res;
        mem2_wb_rd_addr_i = in_mw_rd[4:0];
        mem2_wb_write_rd_i = in_mw_wop[4];
        mem2_wb_mem_oper_i = pipe_ctrl_pkg::mem_oper_t'(in_mw_wop[3:0]);
        mem2_wb_alu_result_i = mw_res;
        lsu_rdata_i = lsu_data;
        mem2_stall_needed_i = in_stl[1];
        lsu_req_stall_i = in_stl[0];
        {id_is_csr_i, ex_is_csr_i, mem1_is_csr_i, mem2_is_csr_i} = in_csr[3:0];
        mem_trap_i = pipe_ctrl_pkg::exc_t'(in_trap[4:0]);
        ex_new_pc_en_i = in_br[0];
        current_plvl_i = pipe_ctrl_pkg::priv_lvl_e'(in_plvl[1:0]);
        csr_mstatus_i = in_mst[3:0];
        irq_pending_i = in_irq[2:0];
    endtask

    task automatic check_outputs();
        check_val("fwd_*_rs*_o", {fwd_ex_mem1_rs1_o, fwd_ex_mem1_rs2_o, fwd_mem1_mem2_rs1_o,
            fwd_mem1_mem2_rs2_o, fwd_mem2_wb_rs1_o, fwd_mem2_wb_rs2_o}, exp_fwd);
        check_val("fwd_ex_mem1_data_o", fwd_ex_mem1_data_o, em_res);
        check_val("fwd_mem1_mem2_data_o", fwd_mem1_mem2_data_o, mm_res);
        check_val("fwd_mem2_wb_data_o", fwd_mem2_wb_data_o, exp_wbsel[0] ? lsu_data : mw_res);
        // stage order if_id, id_ex, ex_mem1, mem1_mem2, mem2_wb
        check_val("*_stall_o", {if_id_stall_o, id_ex_stall_o, ex_mem1_stall_o,
            mem1_mem2_stall_o, mem2_wb_stall_o}, exp_stall);
        check_val("*_flush_o", {if_id_flush_o, id_ex_flush_o, ex_mem1_flush_o,
            mem1_mem2_flush_o, mem2_wb_flush_o}, exp_flush);
        check_val("new_pc_en_o", new_pc_en_o, exp_npc);
        check_val("pc_sel_o", pc_sel_o, exp_psel);
        check_val("csr_mret_o", csr_mret_o, exp_mret);
        check_val("is_trap_o", is_trap_o, exp_trap);
        check_val("csr_mcause_o", csr_mcause_o, exp_mcause);
    endtask

    initial
    begin
        int fd;
        int nfields;
        int cyc;
        int c;
        int err_before;
        int wait_cnt;
        string line;
        string tag;

        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        total_cycles = 0;
        timed_out = 1'b0;
        void'($urandom(32'h58b0));

        // quiet pipe with no trap, no branch, M mode and interrupts off
        {in_rs1, in_rs2, in_em_rd, in_em_wop, in_mm_rd, in_mm_wop} = '0;
        {in_mw_rd, in_mw_wop, in_stl, in_csr, in_br, in_mst, in_irq} = '0;
        in_trap = 'h10;
        in_plvl = 3;
        {em_res, mm_res, mw_res, lsu_data} = '0;
        apply_inputs();

        wait_cnt = 0;
        while (!rstn_i && !timed_out)
        begin
            @(posedge clk_i);
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT)
                timed_out = 1'b1;
        end

        if (timed_out)
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
        else
        begin
            // redirect outputs idle right after reset
            #1;
            err_before = errors;
            check_val("new_pc_en_o", new_pc_en_o, 0);
            check_val("pc_sel_o", pc_sel_o, pipe_ctrl_pkg::PC_JUMP);
            check_val("csr_mret_o", csr_mret_o, 0);
            check_val("is_trap_o", is_trap_o, 0);
            tests_run++;
            if (errors != err_before)
                tests_failed++;
            $display("%-18s %s", "reset", (errors == err_before) ? "ok" : "mismatch");
        end

        fd = $fopen("verif/pipe_ctrl_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test vector file");
            errors++;
        end

        while (fd != 0 && !timed_out && !$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            nfields = $sscanf(line,
                "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                tag, cyc, in_rs1, in_rs2, in_em_rd, in_em_wop, in_mm_rd, in_mm_wop,
                in_mw_rd, in_mw_wop, in_stl, in_csr, in_trap, in_br, in_plvl, in_mst,
                in_irq, exp_fwd, exp_wbsel, exp_stall, exp_flush, exp_npc, exp_psel,
                exp_mret, exp_trap, exp_mcause);
            tests_run++;
            if (nfields != 26 || cyc < 1 || cyc > MAX_TEST_CYCLES)
            begin
                $display("vector line is malformed or has a bad cycle count: %s", line);
                errors++;
                tests_failed++;
                continue;
            end

            err_before = errors;
            em_res = $urandom;
            mm_res = $urandom;
            mw_res = $urandom;
            lsu_data = $urandom;

            // first cycle of the test starts just after an edge
            @(posedge clk_i);
            #2;
            apply_inputs();
            total_cycles++;
            c = 1;
            while (c < cyc && !timed_out)
            begin
                @(posedge clk_i);
                #2;
                c++;
                total_cycles++;
                if (total_cycles > MAX_CYCLES)
                    timed_out = 1'b1;
            end
            if (total_cycles > MAX_CYCLES)
                timed_out = 1'b1;
            if (timed_out)
            begin
                $display("vector loop ran past its budget of %0d cycles", MAX_CYCLES);
                tests_failed++;
                break;
            end

            // outputs of the last cycle sampled just before the edge
            #17;
            check_outputs();
            if (errors != err_before)
                tests_failed++;
            $display("%-18s %s", tag, (errors == err_before) ? "ok" : "mismatch");
        end

        if (fd != 0)
            $fclose(fd);

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
            tests_run, tests_run - tests_failed, tests_failed, errors);
        if (!timed_out && errors == 0 && tests_failed == 0 && tests_run > 1)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pipe_ctrl_props.sv
// ########################################
// concurrent checks bound into pipe_ctrl
// ########################################
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_props
(
    input wire       clk_i,
    input wire       rstn_i,
    // stall requests from the two memory stages
    input wire       mem2_stall_needed_i,
    input wire       lsu_req_stall_i,
    // load-use flush before the redirect merge
    input wire       hz_ex_mem1_flush_i,
    input wire       fwd_ex_mem1_rs1_i,
    input wire       fwd_ex_mem1_rs2_i,
    input wire [3:0] ex_mem1_mem_oper_i,
    input wire       csr_mret_i,
    input wire [1:0] pc_sel_i
);

    // a stall from either memory stage reaches EX/MEM1 and holds its instruction
    stall_blocks_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem2_stall_needed_i || lsu_req_stall_i) |-> !hz_ex_mem1_flush_i)
        else $error("EX/MEM1 load-use flush raised while EX/MEM1 is stalled");

    // load data is not back in EX/MEM1
    no_load_fwd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (fwd_ex_mem1_rs1_i || fwd_ex_mem1_rs2_i)
        |-> !pipe_ctrl_pkg::is_load(pipe_ctrl_pkg::mem_oper_t'(ex_mem1_mem_oper_i)))
        else $error("EX/MEM1 forwards a load result");

    mret_to_mepc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        csr_mret_i |-> (pc_sel_i == pipe_ctrl_pkg::PC_MEPC))
        else $error("MRET without a MEPC fetch redirect");

endmodule

`default_nettype wire

// File: source/pipe_ctrl.sv
// ########################################
// pipeline control top: stage bundles,
// forwarding, hazard and trap units
// ########################################
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl
#(
    parameter int DATA_W = 32
)
(
    input wire clk_i,
    input wire rstn_i,

    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs1_addr_i,
    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs2_addr_i,
    input wire ex_new_pc_en_i,

    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] ex_mem1_rd_addr_i,
    input wire ex_mem1_write_rd_i,
    input var pipe_ctrl_pkg::mem_oper_t ex_mem1_mem_oper_i,
    input wire [DATA_W-1:0] ex_mem1_alu_result_i,

    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] mem1_mem2_rd_addr_i,
    input wire mem1_mem2_write_rd_i,
    input var pipe_ctrl_pkg::mem_oper_t mem1_mem2_mem_oper_i,
    input wire [DATA_W-1:0] mem1_mem2_alu_result_i,

    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] mem2_wb_rd_addr_i,
    input wire mem2_wb_write_rd_i,
    input var pipe_ctrl_pkg::mem_oper_t mem2_wb_mem_oper_i,
    input wire [DATA_W-1:0] mem2_wb_alu_result_i,
    input wire [DATA_W-1:0] lsu_rdata_i,

    input wire mem2_stall_needed_i,
    input var pipe_ctrl_pkg::exc_t mem_trap_i,
    input wire lsu_req_stall_i,

    input wire id_is_csr_i,
    input wire ex_is_csr_i,
    input wire mem1_is_csr_i,
    input wire mem2_is_csr_i,

    input var pipe_ctrl_pkg::priv_lvl_e current_plvl_i,
    input var pipe_ctrl_pkg::mstatus_t csr_mstatus_i,
    input var pipe_ctrl_pkg::irqs_t irq_pending_i,

    output logic fwd_ex_mem1_rs1_o,
    output logic fwd_ex_mem1_rs2_o,
    output logic [DATA_W-1:0] fwd_ex_mem1_data_o,
    output logic fwd_mem1_mem2_rs1_o,
    output logic fwd_mem1_mem2_rs2_o,
    output logic [DATA_W-1:0] fwd_mem1_mem2_data_o,
    output logic fwd_mem2_wb_rs1_o,
    output logic fwd_mem2_wb_rs2_o,
    output logic [DATA_W-1:0] fwd_mem2_wb_data_o,

    // fetch redirect
    output logic new_pc_en_o,
    output pipe_ctrl_pkg::pc_sel_t pc_sel_o,

    // CSR file
    output logic csr_mret_o,
    output pipe_ctrl_pkg::mcause_t csr_mcause_o,
    output logic is_trap_o,

    output logic if_id_stall_o,
    output logic if_id_flush_o,
    output logic id_ex_stall_o,
    output logic id_ex_flush_o,
    output logic ex_mem1_stall_o,
    output logic ex_mem1_flush_o,
    output logic mem1_mem2_stall_o,
    output logic mem1_mem2_flush_o,
    output logic mem2_wb_stall_o,
    output logic mem2_wb_flush_o
);

    logic hz_id_ex_flush;
    logic hz_ex_mem1_flush;
    logic redirect_flush;
    logic branch_only;

    // the top is the producer side of all three bundles
    stage_if #(.DATA_W(DATA_W)) ex_mem1 ();
    stage_if #(.DATA_W(DATA_W)) mem1_mem2 ();
    stage_if #(.DATA_W(DATA_W)) mem2_wb ();

    assign ex_mem1.rd_addr = ex_mem1_rd_addr_i;
    assign ex_mem1.write_rd = ex_mem1_write_rd_i;
    assign ex_mem1.mem_oper = ex_mem1_mem_oper_i;
    assign ex_mem1.result = ex_mem1_alu_result_i;
    // LSU data only exists at WB
    assign ex_mem1.lsu_rdata = '0;

    assign mem1_mem2.rd_addr = mem1_mem2_rd_addr_i;
    assign mem1_mem2.write_rd = mem1_mem2_write_rd_i;
    assign mem1_mem2.mem_oper = mem1_mem2_mem_oper_i;
    assign mem1_mem2.result = mem1_mem2_alu_result_i;
    assign mem1_mem2.lsu_rdata = '0;

    assign mem2_wb.rd_addr = mem2_wb_rd_addr_i;
    assign mem2_wb.write_rd = mem2_wb_write_rd_i;
    assign mem2_wb.mem_oper = mem2_wb_mem_oper_i;
    assign mem2_wb.result = mem2_wb_alu_result_i;
    assign mem2_wb.lsu_rdata = lsu_rdata_i;

    forward_unit #(.DATA_W(DATA_W)) u_forward (
        .id_ex_rs1_addr_i    (id_ex_rs1_addr_i),
        .id_ex_rs2_addr_i    (id_ex_rs2_addr_i),
        .ex_mem1             (ex_mem1),
        .mem1_mem2           (mem1_mem2),
        .mem2_wb             (mem2_wb),
        .fwd_ex_mem1_rs1_o   (fwd_ex_mem1_rs1_o),
        .fwd_ex_mem1_rs2_o   (fwd_ex_mem1_rs2_o),
        .fwd_mem1_mem2_rs1_o (fwd_mem1_mem2_rs1_o),
        .fwd_mem1_mem2_rs2_o (fwd_mem1_mem2_rs2_o),
        .fwd_mem2_wb_rs1_o   (fwd_mem2_wb_rs1_o),
        .fwd_mem2_wb_rs2_o   (fwd_mem2_wb_rs2_o),
        .fwd_ex_mem1_data_o  (fwd_ex_mem1_data_o),
        .fwd_mem1_mem2_data_o(fwd_mem1_mem2_data_o),
        .fwd_mem2_wb_data_o  (fwd_mem2_wb_data_o)
    );

    hazard_unit u_hazard (
        .id_ex_rs1_addr_i   (id_ex_rs1_addr_i),
        .id_ex_rs2_addr_i   (id_ex_rs2_addr_i),
        .ex_mem1            (ex_mem1),
        .mem1_mem2          (mem1_mem2),
        .fwd_ex_mem1_rs1_i  (fwd_ex_mem1_rs1_o),
        .fwd_ex_mem1_rs2_i  (fwd_ex_mem1_rs2_o),
        .mem2_stall_needed_i(mem2_stall_needed_i),
        .lsu_req_stall_i    (lsu_req_stall_i),
        .id_is_csr_i        (id_is_csr_i),
        .ex_is_csr_i        (ex_is_csr_i),
        .mem1_is_csr_i      (mem1_is_csr_i),
        .mem2_is_csr_i      (mem2_is_csr_i),
        .if_id_stall_o      (if_id_stall_o),
        .if_id_flush_o      (if_id_flush_o),
        .id_ex_stall_o      (id_ex_stall_o),
        .id_ex_flush_o      (hz_id_ex_flush),
        .ex_mem1_stall_o    (ex_mem1_stall_o),
        .ex_mem1_flush_o    (hz_ex_mem1_flush),
        .mem1_mem2_stall_o  (mem1_mem2_stall_o),
        .mem1_mem2_flush_o  (mem1_mem2_flush_o),
        .mem2_wb_stall_o    (mem2_wb_stall_o),
        .mem2_wb_flush_o    (mem2_wb_flush_o)
    );

    trap_unit u_trap (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .mem_trap_i      (mem_trap_i),
        .ex_new_pc_en_i  (ex_new_pc_en_i),
        .current_plvl_i  (current_plvl_i),
        .csr_mstatus_i   (csr_mstatus_i),
        .irq_pending_i   (irq_pending_i),
        .new_pc_en_o     (new_pc_en_o),
        .pc_sel_o        (pc_sel_o),
        .csr_mret_o      (csr_mret_o),
        .is_trap_o       (is_trap_o),
        .csr_mcause_o    (csr_mcause_o),
        .redirect_flush_o(redirect_flush),
        .branch_only_o   (branch_only)
    );

    // redirects flush regardless of stalls, a branch spares EX/MEM1
    assign id_ex_flush_o = hz_id_ex_flush || redirect_flush;
    assign ex_mem1_flush_o = hz_ex_mem1_flush || (redirect_flush && !branch_only);

endmodule

`default_nettype wire

// File: source/trap_unit.sv
// ########################################
// interrupt priority and redirect FSM
// ########################################
`timescale 1ns/100ps
`default_nettype none

module trap_unit
(
    input wire clk_i,
    input wire rstn_i,

    input var pipe_ctrl_pkg::exc_t mem_trap_i,
    // taken branch resolved in EX
    input wire ex_new_pc_en_i,

    input var pipe_ctrl_pkg::priv_lvl_e current_plvl_i,
    input var pipe_ctrl_pkg::mstatus_t csr_mstatus_i,
    input var pipe_ctrl_pkg::irqs_t irq_pending_i,

    output logic new_pc_en_o,
    output pipe_ctrl_pkg::pc_sel_t pc_sel_o,
    output logic csr_mret_o,
    output logic is_trap_o,
    output pipe_ctrl_pkg::mcause_t csr_mcause_o,
    // branch_only_o limits the flush to ID/EX
    output logic redirect_flush_o,
    output logic branch_only_o
);

    typedef enum logic
    {
        DECODE,
        IRQ_TAKEN
    } state_t;

    state_t state_q;
    state_t state_d;

    logic irq_en;
    logic irq_take;
    logic [3:0] irq_code;

    // mie is ignored in U mode, interrupts always reach M
    assign irq_en = csr_mstatus_i.mie || (current_plvl_i == pipe_ctrl_pkg::PRIV_LVL_U);
    // one cycle of hold-off after an interrupt redirect
    assign irq_take = irq_en && (|irq_pending_i) && (state_q == DECODE);

    // software over timer over external
    always_comb
    begin
        if (irq_pending_i.m_software)
            irq_code = pipe_ctrl_pkg::IRQ_MSI;
        else if (irq_pending_i.m_timer)
            irq_code = pipe_ctrl_pkg::IRQ_MTI;
        else if (irq_pending_i.m_external)
            irq_code = pipe_ctrl_pkg::IRQ_MEI;
        else
            irq_code = 4'd0;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= DECODE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        // IRQ_TAKEN always falls back to DECODE
        state_d = DECODE;
        new_pc_en_o = 1'b0;
        pc_sel_o = pipe_ctrl_pkg::PC_JUMP;
        csr_mret_o = 1'b0;
        is_trap_o = 1'b0;
        redirect_flush_o = 1'b0;
        branch_only_o = 1'b0;
        csr_mcause_o.irq = 1'b0;
        csr_mcause_o.trap_code = mem_trap_i[3:0];

        if (mem_trap_i == pipe_ctrl_pkg::MRET)
        begin
            // return to mepc, CSR file restores mie/privilege
            new_pc_en_o = 1'b1;
            pc_sel_o = pipe_ctrl_pkg::PC_MEPC;
            csr_mret_o = 1'b1;
            redirect_flush_o = 1'b1;
        end
        else if (mem_trap_i != pipe_ctrl_pkg::NO_TRAP)
        begin
            new_pc_en_o = 1'b1;
            pc_sel_o = pipe_ctrl_pkg::PC_TRAP;
            is_trap_o = 1'b1;
            redirect_flush_o = 1'b1;
        end
        else if (irq_take)
        begin
            // the MEM2 instruction retires, everything younger is dropped
            new_pc_en_o = 1'b1;
            pc_sel_o = pipe_ctrl_pkg::PC_TRAP;
            is_trap_o = 1'b1;
            redirect_flush_o = 1'b1;
            csr_mcause_o.irq = 1'b1;
            csr_mcause_o.trap_code = irq_code;
            state_d = IRQ_TAKEN;
        end
        else if (ex_new_pc_en_i)
        begin
            // predicted not taken, only the instruction in ID/EX is wrong
            new_pc_en_o = 1'b1;
            redirect_flush_o = 1'b1;
            branch_only_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
// ########################################
// load-use detection and stall/flush chain
// ########################################
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
(
    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs1_addr_i,
    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs2_addr_i,

    stage_if.consumer ex_mem1,
    stage_if.consumer mem1_mem2,

    // EX/MEM1 forwarding already covers a MEM2 load
    input wire fwd_ex_mem1_rs1_i,
    input wire fwd_ex_mem1_rs2_i,

    input wire mem2_stall_needed_i,
    input wire lsu_req_stall_i,

    // CSR instruction present per stage
    input wire id_is_csr_i,
    input wire ex_is_csr_i,
    input wire mem1_is_csr_i,
    input wire mem2_is_csr_i,

    output logic if_id_stall_o,
    output logic if_id_flush_o,
    output logic id_ex_stall_o,
    output logic id_ex_flush_o,
    output logic ex_mem1_stall_o,
    output logic ex_mem1_flush_o,
    output logic mem1_mem2_stall_o,
    output logic mem1_mem2_flush_o,
    output logic mem2_wb_stall_o,
    output logic mem2_wb_flush_o
);

    logic load_in_mem1;
    logic load_in_mem2_rs1;
    logic load_in_mem2_rs2;
    logic load_use;

    // split memory stage, a use right behind a load waits two cycles
    assign load_in_mem1 = pipe_ctrl_pkg::is_load(ex_mem1.mem_oper)
        && ex_mem1.write_rd && (ex_mem1.rd_addr != '0)
        && ((ex_mem1.rd_addr == id_ex_rs1_addr_i) || (ex_mem1.rd_addr == id_ex_rs2_addr_i));

    assign load_in_mem2_rs1 = pipe_ctrl_pkg::is_load(mem1_mem2.mem_oper)
        && mem1_mem2.write_rd && (mem1_mem2.rd_addr != '0)
        && (mem1_mem2.rd_addr == id_ex_rs1_addr_i);
    assign load_in_mem2_rs2 = pipe_ctrl_pkg::is_load(mem1_mem2.mem_oper)
        && mem1_mem2.write_rd && (mem1_mem2.rd_addr != '0)
        && (mem1_mem2.rd_addr == id_ex_rs2_addr_i);

    // a younger ALU op in EX/MEM1 overrides the MEM2 load value
    assign load_use = load_in_mem1
        || (load_in_mem2_rs1 && !fwd_ex_mem1_rs1_i)
        || (load_in_mem2_rs2 && !fwd_ex_mem1_rs2_i);

    // stalls run from the back of the pipe toward fetch
    assign mem2_wb_stall_o = 1'b0;
    assign mem1_mem2_stall_o = mem2_stall_needed_i || mem2_wb_stall_o;
    assign ex_mem1_stall_o = lsu_req_stall_i || mem1_mem2_stall_o;
    assign id_ex_stall_o = load_use || ex_mem1_stall_o;
    // CSR side effects must settle before the next fetch
    assign if_id_stall_o = id_ex_stall_o || ex_is_csr_i || mem1_is_csr_i || mem2_is_csr_i;

    // bubbles behind the stalled stages
    assign mem2_wb_flush_o = mem2_stall_needed_i;
    assign mem1_mem2_flush_o = lsu_req_stall_i;
    // a held EX/MEM1 keeps its older instruction, so no bubble then
    assign ex_mem1_flush_o = load_use && !ex_mem1_stall_o;
    // only redirects flush ID/EX
    assign id_ex_flush_o = 1'b0;
    assign if_id_flush_o = id_is_csr_i || ex_is_csr_i || mem1_is_csr_i || mem2_is_csr_i;

endmodule

`default_nettype wire

// File: source/forward_unit.sv
// ########################################
// operand forwarding toward the EX stage
// ########################################
`timescale 1ns/100ps
`default_nettype none

module forward_unit
#(
    parameter int DATA_W = 32
)
(
    // sources of the instruction sitting in ID/EX
    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs1_addr_i,
    input wire [pipe_ctrl_pkg::REG_ADDR_W-1:0] id_ex_rs2_addr_i,

    stage_if.consumer ex_mem1,
    stage_if.consumer mem1_mem2,
    stage_if.consumer mem2_wb,

    output logic fwd_ex_mem1_rs1_o,
    output logic fwd_ex_mem1_rs2_o,
    output logic fwd_mem1_mem2_rs1_o,
    output logic fwd_mem1_mem2_rs2_o,
    output logic fwd_mem2_wb_rs1_o,
    output logic fwd_mem2_wb_rs2_o,
    output logic [DATA_W-1:0] fwd_ex_mem1_data_o,
    output logic [DATA_W-1:0] fwd_mem1_mem2_data_o,
    output logic [DATA_W-1:0] fwd_mem2_wb_data_o
);

    logic ex_mem1_can_fwd;
    logic mem1_mem2_can_fwd;
    logic mem2_wb_can_fwd;

    // x0 is hardwired, writing it never produces a value
    // a load in EX/MEM1 only holds its address, its data is not back yet
    assign ex_mem1_can_fwd = ex_mem1.write_rd && (ex_mem1.rd_addr != '0)
        && !pipe_ctrl_pkg::is_load(ex_mem1.mem_oper);
    assign mem1_mem2_can_fwd = mem1_mem2.write_rd && (mem1_mem2.rd_addr != '0);
    assign mem2_wb_can_fwd = mem2_wb.write_rd && (mem2_wb.rd_addr != '0);

    // more than one flag may be set, EX takes the youngest stage
    assign fwd_ex_mem1_rs1_o = ex_mem1_can_fwd && (ex_mem1.rd_addr == id_ex_rs1_addr_i);
    assign fwd_ex_mem1_rs2_o = ex_mem1_can_fwd && (ex_mem1.rd_addr == id_ex_rs2_addr_i);
    assign fwd_mem1_mem2_rs1_o = mem1_mem2_can_fwd && (mem1_mem2.rd_addr == id_ex_rs1_addr_i);
    assign fwd_mem1_mem2_rs2_o = mem1_mem2_can_fwd && (mem1_mem2.rd_addr == id_ex_rs2_addr_i);
    assign fwd_mem2_wb_rs1_o = mem2_wb_can_fwd && (mem2_wb.rd_addr == id_ex_rs1_addr_i);
    assign fwd_mem2_wb_rs2_o = mem2_wb_can_fwd && (mem2_wb.rd_addr == id_ex_rs2_addr_i);

    // ALU result in the two younger stages
    assign fwd_ex_mem1_data_o = ex_mem1.result;
    assign fwd_mem1_mem2_data_o = mem1_mem2.result;

    // by WB the LSU has returned the load data, the result is just the address
    assign fwd_mem2_wb_data_o = pipe_ctrl_pkg::is_load(mem2_wb.mem_oper)
        ? mem2_wb.lsu_rdata : mem2_wb.result;

endmodule

`default_nettype wire

// File: source/stage_if.sv
// ########################################
// destination and result fields of one
// pipeline register
// ########################################
`timescale 1ns/100ps
`default_nettype none

interface stage_if
#(
    parameter int DATA_W = 32
);

    logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] rd_addr;
    logic                                 write_rd;
    pipe_ctrl_pkg::mem_oper_t             mem_oper;
    logic [DATA_W-1:0]                    result;
    // only meaningful in MEM2/WB
    logic [DATA_W-1:0]                    lsu_rdata;

    modport producer (output rd_addr, write_rd, mem_oper, result, lsu_rdata);
    modport consumer (input rd_addr, write_rd, mem_oper, result, lsu_rdata);

endinterface

`default_nettype wire

// File: source/pipe_ctrl_pkg.sv
// ########################################
// pipeline control types and cause codes,
// plus the load test on memory operations
// ########################################
`default_nettype none

package pipe_ctrl_pkg;

    localparam int REG_ADDR_W = 5;

    // memory access carried by a pipeline register
    typedef enum logic [3:0]
    {
        MEM_NONE = 4'h0,
        MEM_LB   = 4'h1,
        MEM_LH   = 4'h2,
        MEM_LW   = 4'h3,
        MEM_LD   = 4'h4,
        MEM_LBU  = 4'h5,
        MEM_LHU  = 4'h6,
        MEM_LWU  = 4'h7,
        MEM_SB   = 4'h8,
        MEM_SH   = 4'h9,
        MEM_SW   = 4'ha,
        MEM_SD   = 4'hb
    } mem_oper_t;

    // trap seen in MEM2, low nibble is the mcause code
    typedef enum logic [4:0]
    {
        EXC_INSTR_MISALIGNED = 5'h00,
        EXC_INSTR_FAULT      = 5'h01,
        EXC_ILLEGAL_INSTR    = 5'h02,
        EXC_BREAKPOINT       = 5'h03,
        EXC_LOAD_MISALIGNED  = 5'h04,
        EXC_LOAD_FAULT       = 5'h05,
        EXC_STORE_MISALIGNED = 5'h06,
        EXC_STORE_FAULT      = 5'h07,
        EXC_ECALL_U          = 5'h08,
        EXC_ECALL_M          = 5'h0b,
        // bit 4 marks the non-exception codes
        NO_TRAP              = 5'h10,
        MRET                 = 5'h11
    } exc_t;

    typedef enum logic [1:0]
    {
        PC_JUMP = 2'd0,
        PC_TRAP = 2'd1,
        PC_MEPC = 2'd2
    } pc_sel_t;

    typedef enum logic [1:0]
    {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    // subset of mstatus seen by the trap logic
    typedef struct packed
    {
        priv_lvl_e mpp;
        logic      mpie;
        logic      mie;
    } mstatus_t;

    typedef struct packed
    {
        logic m_external;
        logic m_timer;
        logic m_software;
    } irqs_t;

    // machine interrupt cause codes
    localparam logic [3:0] IRQ_MSI = 4'd3;
    localparam logic [3:0] IRQ_MTI = 4'd7;
    localparam logic [3:0] IRQ_MEI = 4'd11;

    typedef struct packed
    {
        logic       irq;
        logic [3:0] trap_code;
    } mcause_t;

    // true for every load width
    function automatic logic is_load(input mem_oper_t oper);
        logic load;
        case (oper)
            MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU: load = 1'b1;
            default: load = 1'b0;
        endcase
        return load;
    endfunction

endpackage

`default_nettype wire
